//--- ads_pkg.sv
package ads_pkg;

	typedef logic [7:0]  byte_t;      // one byte on the bus
	typedef logic [6:0]  dev_addr_t;
	typedef logic [23:0] sample_t;    // one adc conversion
	typedef logic [1:0]  rate_sel_t;  // 0 is fastest
	typedef logic [1:0]  chan_t;

	// commands the sequencer hands to the bus engine
	typedef enum logic [1:0] {
		BUS_START,
		BUS_WRITE,
		BUS_READ,
		BUS_STOP
	} bus_cmd_e;

	// steps of one scanned channel
	typedef enum logic [2:0] {
		SCAN_MUX,
		SCAN_SYNC,
		SCAN_WAIT_DRDY,
		SCAN_RDATA,
		SCAN_READ
	} scan_state_e;

	typedef enum logic [3:0] {
		SEQ_IDLE,
		SEQ_START,
		SEQ_ADDR,
		SEQ_BYTE0,   // register or command byte
		SEQ_BYTE1,   // data byte
		SEQ_READ,
		SEQ_STOP,
		SEQ_DRDY     // between sync and rdata
	} seq_state_e;

	localparam byte_t ADS_WREG_CFG0 = 8'h40;
	localparam byte_t ADS_CMD_SYNC  = 8'h08;
	localparam byte_t ADS_CMD_RDATA = 8'h10;

	// mux field for ain0..ain3 against avss
	localparam byte_t ADS_MUX_CODE [0:3] = '{8'h81, 8'h91, 8'hA1, 8'hB1};

	localparam int ADS_RESULT_BYTES = 3;

endpackage

//--- i2c_cmd_if.sv
`timescale 1ns/1ps

interface i2c_cmd_if import ads_pkg::*; ();

	bus_cmd_e cmd;
	byte_t    wbyte;
	logic     ack_out;   // level driven in the ack slot of a read
	logic     go;        // one cycle, only while engine idle

	logic     done;      // one cycle after the last tick
	byte_t    rbyte;
	logic     nack;      // ack bit of a write, 1 = nack

	modport seq (
		output cmd,
		output wbyte,
		output ack_out,
		output go,
		input  done,
		input  rbyte,
		input  nack
	);

	modport eng (
		input  cmd,
		input  wbyte,
		input  ack_out,
		input  go,
		output done,
		output rbyte,
		output nack
	);

endinterface

//--- i2c_rate_div.sv
`timescale 1ns/1ps

module i2c_rate_div import ads_pkg::*; #(
	parameter int DIV_BASE = 2
) (
	input  logic      i2c_clk,
	input  logic      i_rst_n,
	input  rate_sel_t i_rate_sel,
	output logic      o_tick
);

	localparam int CW = DIV_BASE + 4;   // room for the slowest period

	logic [CW-1:0] cnt;
	logic [CW-1:0] term;
	rate_sel_t     rate_q;

	// quarter bit lasts 2^(DIV_BASE + rate) clocks
	assign term = (CW'(1) << (DIV_BASE + int'(rate_q))) - CW'(1);

	assign o_tick = (cnt == term);

	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cnt    <= '0;
			rate_q <= '0;
		end else begin
			// rate code is only taken at the start of a period
			if (cnt == '0) begin
				rate_q <= i_rate_sel;
			end
			if (o_tick) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + CW'(1);
			end
		end
	end

endmodule

//--- i2c_bus_engine.sv
`timescale 1ns/1ps

module i2c_bus_engine import ads_pkg::*; (
	input  logic   i2c_clk,
	input  logic   i_rst_n,
	input  logic   i_tick,
	input  logic   i_scl,
	input  logic   i_sda,
	output logic   o_scl_oe,
	output logic   o_sda_oe,
	i2c_cmd_if.eng bus
);

	bus_cmd_e   cmd_q;
	logic       busy;
	logic [1:0] qtr;       // quarter within the bit
	logic [3:0] bit_cnt;   // 0..7 data, 8 ack
	byte_t      shreg;
	logic       ack_q;
	logic       nack_q;
	logic       done_q;
	logic       scl_oe;
	logic       sda_oe;

	logic is_byte;
	logic ack_slot;
	logic hold;
	logic last_bit;

	assign is_byte  = (cmd_q == BUS_WRITE) || (cmd_q == BUS_READ);
	assign ack_slot = (bit_cnt == 4'd8);
	assign hold     = (qtr == 2'd2) && !i_scl;   // slave stretches the clock
	assign last_bit = !is_byte || ack_slot;

	assign o_scl_oe  = scl_oe;
	assign o_sda_oe  = sda_oe;
	assign bus.done  = done_q;
	assign bus.rbyte = shreg;
	assign bus.nack  = nack_q;

	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			busy    <= 1'b0;
			cmd_q   <= BUS_STOP;
			qtr     <= '0;
			bit_cnt <= '0;
			scl_oe  <= 1'b0;   // bus released
			sda_oe  <= 1'b0;
			nack_q  <= 1'b0;
			done_q  <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (!busy) begin
				if (bus.go) begin
					busy    <= 1'b1;
					cmd_q   <= bus.cmd;
					qtr     <= '0;
					bit_cnt <= '0;
				end
			end else if (i_tick && !hold) begin
				qtr <= qtr + 2'd1;
				case (qtr)
					2'd0: begin
						// scl is low here, so sda may move
						case (cmd_q)
							BUS_START: sda_oe <= 1'b0;
							BUS_STOP:  sda_oe <= 1'b1;
							BUS_WRITE: sda_oe <= ack_slot ? 1'b0 : ~shreg[7];
							default:   sda_oe <= ack_slot ? ~ack_q : 1'b0;
						endcase
					end
					2'd1: scl_oe <= 1'b0;   // scl rises
					2'd2: begin
						if (cmd_q == BUS_START) begin
							sda_oe <= 1'b1;   // start condition
						end else if (cmd_q == BUS_STOP) begin
							sda_oe <= 1'b0;   // stop condition
						end else if (ack_slot) begin
							nack_q <= i_sda;
						end
					end
					default: begin
						if (cmd_q != BUS_STOP) begin
							scl_oe <= 1'b1;   // scl falls, bus stays held after start and bytes
						end
						bit_cnt <= bit_cnt + 4'd1;
						if (last_bit) begin
							busy   <= 1'b0;
							done_q <= 1'b1;
						end
					end
				endcase
			end
		end
	end

	// write bytes shift out msb first; the same shift collects read data
	always_ff @(posedge i2c_clk) begin
		if (!busy && bus.go) begin
			shreg <= bus.wbyte;
			ack_q <= bus.ack_out;
		end else if (busy && i_tick && qtr == 2'd2 && i_scl && is_byte && !ack_slot) begin
			shreg <= {shreg[6:0], i_sda};
		end
	end

endmodule

//--- adc_sequencer.sv
`timescale 1ns/1ps

module adc_sequencer import ads_pkg::*; (
	input  logic      i2c_clk,
	input  logic      i_rst_n,
	input  logic      i_enable,
	input  logic      i_scan_mode,
	input  dev_addr_t i_dev_addr,
	input  byte_t     i_reg_byte,
	input  byte_t     i_w_data,
	input  logic      i_drdy_n,
	output logic      o_ready,
	output logic      o_finish,
	output logic      o_ack_err,
	output sample_t   o_ain0,
	output sample_t   o_ain1,
	output sample_t   o_ain2,
	output sample_t   o_ain3,
	i2c_cmd_if.seq    bus
);

	seq_state_e  state_q;
	scan_state_e scan_q;
	chan_t       chan_q;
	logic        scan_run;   // mode of the running transaction set
	logic        abort_q;    // address was nacked
	logic [1:0]  rd_cnt;
	sample_t     rd_data;

	logic  is_read;
	logic  two_bytes;
	logic  last_rd;
	byte_t first_byte;

	assign is_read   = scan_run && (scan_q == SCAN_READ);
	assign two_bytes = !scan_run || (scan_q == SCAN_MUX);
	assign last_rd   = (rd_cnt == 2'(ADS_RESULT_BYTES - 1));
	assign o_ready   = (state_q == SEQ_IDLE);

	always_comb begin
		if (!scan_run) begin
			first_byte = i_reg_byte;
		end else begin
			case (scan_q)
				SCAN_MUX:  first_byte = ADS_WREG_CFG0;
				SCAN_SYNC: first_byte = ADS_CMD_SYNC;
				default:   first_byte = ADS_CMD_RDATA;
			endcase
		end
	end

	// command follows the state, the engine latches it on go
	always_comb begin
		bus.cmd   = BUS_WRITE;
		bus.wbyte = {i_dev_addr, is_read};
		case (state_q)
			SEQ_START: bus.cmd = BUS_START;
			SEQ_BYTE0: bus.wbyte = first_byte;
			SEQ_BYTE1: bus.wbyte = scan_run ? ADS_MUX_CODE[chan_q] : i_w_data;
			SEQ_READ:  bus.cmd = BUS_READ;
			SEQ_STOP:  bus.cmd = BUS_STOP;
			default: ;
		endcase
	end

	assign bus.ack_out = last_rd;   // nack the final result byte

	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_q   <= SEQ_IDLE;
			scan_q    <= SCAN_MUX;
			chan_q    <= '0;
			scan_run  <= 1'b0;
			abort_q   <= 1'b0;
			rd_cnt    <= '0;
			bus.go    <= 1'b0;
			o_finish  <= 1'b0;
			o_ack_err <= 1'b0;
			o_ain0    <= '0;
			o_ain1    <= '0;
			o_ain2    <= '0;
			o_ain3    <= '0;
		end else begin
			bus.go    <= 1'b0;
			o_finish  <= 1'b0;
			o_ack_err <= 1'b0;
			case (state_q)
				SEQ_IDLE: begin
					if (i_enable) begin
						scan_run <= i_scan_mode;
						abort_q  <= 1'b0;
						state_q  <= SEQ_START;
						bus.go   <= 1'b1;
					end
				end
				SEQ_START: begin
					if (bus.done) begin
						state_q <= SEQ_ADDR;
						bus.go  <= 1'b1;
					end
				end
				SEQ_ADDR: begin
					if (bus.done) begin
						bus.go <= 1'b1;
						rd_cnt <= '0;
						if (bus.nack) begin
							abort_q <= 1'b1;
							state_q <= SEQ_STOP;
						end else if (is_read) begin
							state_q <= SEQ_READ;
						end else begin
							state_q <= SEQ_BYTE0;
						end
					end
				end
				SEQ_BYTE0: begin
					if (bus.done) begin
						bus.go  <= 1'b1;
						state_q <= two_bytes ? SEQ_BYTE1 : SEQ_STOP;
					end
				end
				SEQ_BYTE1: begin
					if (bus.done) begin
						bus.go  <= 1'b1;
						state_q <= SEQ_STOP;
					end
				end
				SEQ_READ: begin
					if (bus.done) begin
						bus.go <= 1'b1;
						rd_cnt <= rd_cnt + 2'd1;
						if (last_rd) begin
							state_q <= SEQ_STOP;
						end
					end
				end
				SEQ_STOP: begin
					if (bus.done) begin
						if (abort_q) begin
							o_ack_err <= 1'b1;   // scan step kept for a retry
							state_q   <= SEQ_IDLE;
						end else if (!scan_run) begin
							o_finish <= 1'b1;
							state_q  <= SEQ_IDLE;
						end else begin
							case (scan_q)
								SCAN_MUX: begin
									scan_q  <= SCAN_SYNC;
									state_q <= SEQ_START;
									bus.go  <= 1'b1;
								end
								SCAN_SYNC: begin
									scan_q  <= SCAN_WAIT_DRDY;
									state_q <= SEQ_DRDY;
								end
								SCAN_RDATA: begin
									scan_q  <= SCAN_READ;
									state_q <= SEQ_START;
									bus.go  <= 1'b1;
								end
								SCAN_READ: begin
									case (chan_q)
										2'd0: o_ain0 <= rd_data;
										2'd1: o_ain1 <= rd_data;
										2'd2: o_ain2 <= rd_data;
										default: o_ain3 <= rd_data;
									endcase
									chan_q   <= chan_q + 2'd1;
									scan_q   <= SCAN_MUX;
									o_finish <= 1'b1;
									state_q  <= SEQ_IDLE;
								end
								default: state_q <= SEQ_IDLE;
							endcase
						end
					end
				end
				SEQ_DRDY: begin
					if (!i_drdy_n) begin   // conversion ready
						scan_q  <= SCAN_RDATA;
						state_q <= SEQ_START;
						bus.go  <= 1'b1;
					end
				end
				default: state_q <= SEQ_IDLE;
			endcase
		end
	end

	// result bytes arrive msb first
	always_ff @(posedge i2c_clk) begin
		if (state_q == SEQ_READ && bus.done) begin
			rd_data <= {rd_data[15:0], bus.rbyte};
		end
	end

endmodule

//--- ads_i2c_ctrl.sv
`timescale 1ns/1ps

module ads_i2c_ctrl import ads_pkg::*; #(
	parameter int DIV_BASE = 2
) (
	input  logic      i2c_clk,
	input  logic      i_rst_n,
	input  logic      i_enable,
	input  logic      i_scan_mode,
	input  rate_sel_t i_rate_sel,
	input  dev_addr_t i_dev_addr,
	input  byte_t     i_reg_byte,
	input  byte_t     i_w_data,
	input  logic      i_drdy_n,
	input  logic      i_scl,       // resolved line levels
	input  logic      i_sda,
	output logic      o_scl_oe,    // 1 pulls the line low
	output logic      o_sda_oe,
	output logic      o_ready,
	output logic      o_finish,
	output logic      o_ack_err,
	output sample_t   o_ain0,
	output sample_t   o_ain1,
	output sample_t   o_ain2,
	output sample_t   o_ain3
);

	logic tick;

	i2c_cmd_if u_cmd_if ();

	i2c_rate_div #(
		.DIV_BASE (DIV_BASE)
	) u_rate_div (
		.i2c_clk    (i2c_clk),
		.i_rst_n    (i_rst_n),
		.i_rate_sel (i_rate_sel),
		.o_tick     (tick)
	);

	i2c_bus_engine u_bus_engine (
		.i2c_clk  (i2c_clk),
		.i_rst_n  (i_rst_n),
		.i_tick   (tick),
		.i_scl    (i_scl),
		.i_sda    (i_sda),
		.o_scl_oe (o_scl_oe),
		.o_sda_oe (o_sda_oe),
		.bus      (u_cmd_if.eng)
	);

	adc_sequencer u_sequencer (
		.i2c_clk     (i2c_clk),
		.i_rst_n     (i_rst_n),
		.i_enable    (i_enable),
		.i_scan_mode (i_scan_mode),
		.i_dev_addr  (i_dev_addr),
		.i_reg_byte  (i_reg_byte),
		.i_w_data    (i_w_data),
		.i_drdy_n    (i_drdy_n),
		.o_ready     (o_ready),
		.o_finish    (o_finish),
		.o_ack_err   (o_ack_err),
		.o_ain0      (o_ain0),
		.o_ain1      (o_ain1),
		.o_ain2      (o_ain2),
		.o_ain3      (o_ain3),
		.bus         (u_cmd_if.seq)
	);

endmodule

//--- ads_adc_model.sv
`timescale 1ns/1ps

module ads_adc_model import ads_pkg::*; #(
	parameter dev_addr_t DEV_ADDR = 7'h45
) (
	input  logic i2c_clk,
	input  logic i_scl_oe,    // master enables pull low when 1
	input  logic i_sda_oe,
	output logic o_scl,       // resolved lines with pull-up
	output logic o_sda,
	output logic o_drdy_n
);

	logic    sda_oe_s = 1'b0;   // slave side of the wired-and
	logic    drdy_n_q = 1'b1;
	logic    prev_scl = 1'b1;
	logic    prev_sda = 1'b1;
	int      bit_cnt = 0;
	byte_t   shift;
	byte_t   tx;
	logic    in_addr = 1'b0;
	logic    addressed = 1'b0;
	logic    rd_mode = 1'b0;
	logic    tx_first = 1'b0;
	logic    m_ack = 1'b0;
	int      wr_idx = 0;
	int      rd_idx = 0;
	byte_t   first_cmd;
	byte_t   mux = 8'h81;
	int      sync_cnt = 0;
	int      seen_sync = 0;
	int      drdy_wait = 0;

	// scoreboard read by the testbench
	byte_t   wr_log[$];
	byte_t   mux_log[$];
	int      ack_cnt = 0;
	int      nack_cnt = 0;
	int      stop_cnt = 0;
	bit      rdata_early = 1'b0;
	sample_t samples[4];

	assign o_scl    = ~i_scl_oe;
	assign o_sda    = ~(i_sda_oe | sda_oe_s);
	assign o_drdy_n = drdy_n_q;

	always @(o_scl or o_sda) begin
		if (o_scl && prev_scl && prev_sda && !o_sda) begin   // start
			bit_cnt   = 0;
			in_addr   = 1'b1;
			addressed = 1'b0;
			rd_mode   = 1'b0;
			sda_oe_s  = 1'b0;
		end else if (o_scl && prev_scl && !prev_sda && o_sda) begin   // stop
			stop_cnt++;
			bit_cnt   = 0;
			in_addr   = 1'b0;
			addressed = 1'b0;
			sda_oe_s  = 1'b0;
		end else if (o_scl && !prev_scl) begin
			if (bit_cnt < 8) begin
				if (!(addressed && rd_mode)) begin
					shift = {shift[6:0], o_sda};
				end
				bit_cnt++;
			end else if (bit_cnt == 8) begin
				if (addressed && rd_mode) begin
					m_ack = !o_sda;   // master ack of a read byte
				end
				bit_cnt = 9;
			end
		end else if (!o_scl && prev_scl) begin
			if (bit_cnt == 8) begin
				if (in_addr) begin
					in_addr = 1'b0;
					if (shift[7:1] == DEV_ADDR) begin
						addressed = 1'b1;
						rd_mode   = shift[0];
						sda_oe_s  = 1'b1;
						tx_first  = 1'b1;
						rd_idx    = 0;
						wr_idx    = 0;
						ack_cnt++;
						wr_log.push_back(shift);
					end else begin
						nack_cnt++;
					end
				end else if (addressed && rd_mode) begin
					sda_oe_s = 1'b0;   // master owns the ack slot
				end else if (addressed) begin
					sda_oe_s = 1'b1;
					ack_cnt++;
					wr_log.push_back(shift);
					if (wr_idx == 0) begin
						first_cmd = shift;
						if (shift == ADS_CMD_SYNC) begin
							sync_cnt++;
						end
						if (shift == ADS_CMD_RDATA && drdy_n_q && sync_cnt != 0) begin
							rdata_early = 1'b1;
						end
					end else if (wr_idx == 1 && first_cmd == ADS_WREG_CFG0) begin
						mux = shift;
						mux_log.push_back(shift);
					end
					wr_idx++;
				end
			end else if (bit_cnt == 9) begin
				bit_cnt = 0;
				if (addressed && rd_mode && (tx_first || m_ack)) begin
					case (rd_idx)
						0:       tx = samples[mux[5:4]][23:16];
						1:       tx = samples[mux[5:4]][15:8];
						default: tx = samples[mux[5:4]][7:0];
					endcase
					rd_idx++;
					tx_first = 1'b0;
					sda_oe_s = ~tx[7];
				end else begin
					sda_oe_s = 1'b0;
					if (rd_mode) begin
						addressed = 1'b0;   // nack ends the read
					end
				end
			end else if (addressed && rd_mode && bit_cnt >= 1 && bit_cnt <= 7) begin
				sda_oe_s = ~tx[3'(7 - bit_cnt)];
			end
		end
		prev_scl = o_scl;
		prev_sda = o_sda;
	end

	// conversion timing after each sync
	always @(posedge i2c_clk) begin
		#2;
		if (sync_cnt != seen_sync) begin
			seen_sync = sync_cnt;
			drdy_wait = 20 + int'($urandom % 181);
			drdy_n_q  = 1'b1;
		end else if (drdy_wait > 0) begin
			drdy_wait--;
			if (drdy_wait == 0) begin
				samples[mux[5:4]] = sample_t'($urandom);
				drdy_n_q = 1'b0;
			end
		end
	end

endmodule

//--- tb_ads_i2c_properties.sv
`timescale 1ns/1ps

module tb_ads_i2c_properties import ads_pkg::*; (
	input logic     i2c_clk,
	input logic     i_rst_n,
	input logic     i_scl,
	input logic     i_sda,
	input logic     o_scl_oe,
	input logic     o_sda_oe,
	input logic     o_finish,
	input logic     o_ack_err,
	input bus_cmd_e eng_cmd,
	input logic     eng_busy
);

	// sda moves under a high scl only for start or stop
	a_sda_edge: assert property (@(posedge i2c_clk) disable iff (!i_rst_n)
		(i_scl && $past(i_scl) && (i_sda != $past(i_sda))) |->
		(eng_busy && ((!i_sda && eng_cmd == BUS_START) || (i_sda && eng_cmd == BUS_STOP))))
		else $error("sda changed while scl high outside start or stop");

	a_one_result: assert property (@(posedge i2c_clk) disable iff (!i_rst_n)
		!(o_finish && o_ack_err))
		else $error("finish and ack error high together");

	a_reset_release: assert property (@(posedge i2c_clk)
		!i_rst_n |-> (!o_scl_oe && !o_sda_oe))
		else $error("bus driven during reset");

endmodule

//--- tb_ads_i2c.sv
`timescale 1ns/1ps

module tb_ads_i2c import ads_pkg::*; ();

	localparam int DIV_BASE  = 1;
	localparam int TICK_FAST = 1 << DIV_BASE;
	localparam int TICK_SLOW = 1 << (DIV_BASE + 3);
	// ticks per channel are 116 for the mux write, 80 for sync, 80 for rdata and 152 for the read
	localparam int CHAN_CYC  = 428 * TICK_SLOW + 200 + 64;
	localparam int LIMIT     = 2 * (8 + 116 * TICK_FAST + 44 * TICK_FAST + 128 + 8 * CHAN_CYC);

	logic      i2c_clk = 1'b0;
	logic      i_rst_n;
	logic      i_enable;
	logic      i_scan_mode;
	rate_sel_t i_rate_sel;
	dev_addr_t i_dev_addr;
	byte_t     i_reg_byte;
	byte_t     i_w_data;
	logic      drdy_n;
	logic      scl;
	logic      sda;
	logic      scl_oe;
	logic      sda_oe;
	logic      o_ready;
	logic      o_finish;
	logic      o_ack_err;
	sample_t   ain_vec [4];
	sample_t   prev_ain [4];
	int        cycles = 0;
	bit        ended = 1'b0;

	ads_i2c_ctrl #(
		.DIV_BASE (DIV_BASE)
	) i_ads_i2c_ctrl (
		.i2c_clk     (i2c_clk),
		.i_rst_n     (i_rst_n),
		.i_enable    (i_enable),
		.i_scan_mode (i_scan_mode),
		.i_rate_sel  (i_rate_sel),
		.i_dev_addr  (i_dev_addr),
		.i_reg_byte  (i_reg_byte),
		.i_w_data    (i_w_data),
		.i_drdy_n    (drdy_n),
		.i_scl       (scl),
		.i_sda       (sda),
		.o_scl_oe    (scl_oe),
		.o_sda_oe    (sda_oe),
		.o_ready     (o_ready),
		.o_finish    (o_finish),
		.o_ack_err   (o_ack_err),
		.o_ain0      (ain_vec[0]),
		.o_ain1      (ain_vec[1]),
		.o_ain2      (ain_vec[2]),
		.o_ain3      (ain_vec[3])
	);

	ads_adc_model u_adc_model (
		.i2c_clk  (i2c_clk),
		.i_scl_oe (scl_oe),
		.i_sda_oe (sda_oe),
		.o_scl    (scl),
		.o_sda    (sda),
		.o_drdy_n (drdy_n)
	);

	bind ads_i2c_ctrl tb_ads_i2c_properties u_props (
		.i2c_clk   (i2c_clk),
		.i_rst_n   (i_rst_n),
		.i_scl     (i_scl),
		.i_sda     (i_sda),
		.o_scl_oe  (o_scl_oe),
		.o_sda_oe  (o_sda_oe),
		.o_finish  (o_finish),
		.o_ack_err (o_ack_err),
		.eng_cmd   (u_bus_engine.cmd_q),
		.eng_busy  (u_bus_engine.busy)
	);

	always #20 i2c_clk = ~i2c_clk;

	always @(posedge i2c_clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			ended = 1'b1;
			$display("timeout after %0d cycles without a result", cycles);
			$display("Verification failed");
			$fatal(1, "run limit reached");
		end
	end

	// catches a stop from a failing property
	final begin
		if (!ended) begin
			$display("Verification failed");
		end
	end

	task automatic check(input bit ok, input string msg);
		assert (ok) else begin
			ended = 1'b1;
			$display("mismatch at %0t ns: %s", $time, msg);
			$display("Verification failed");
			$fatal(1, "check failed");
		end
	endtask

	task automatic start_set();
		@(posedge i2c_clk);
		#2 i_enable = 1'b1;
		@(posedge i2c_clk);
		#2 i_enable = 1'b0;
	endtask

	task automatic wait_result();
		do @(negedge i2c_clk); while (!o_finish && !o_ack_err);
	endtask

	initial begin
		int wr_base;
		int ack_base;
		int stop_base;
		int nack_base;
		int mux_base;
		int ch;

		void'($urandom(32'h6137_4256));
		i_rst_n     = 1'b0;
		i_enable    = 1'b0;
		i_scan_mode = 1'b0;
		i_rate_sel  = 2'd0;
		i_dev_addr  = 7'h45;
		i_reg_byte  = 8'h00;
		i_w_data    = 8'h00;
		repeat (8) @(posedge i2c_clk);
		#2 i_rst_n = 1'b1;
		@(negedge i2c_clk);
		check(!scl_oe && !sda_oe && o_ready && !o_finish && !o_ack_err,
			"bus, ready or result flags wrong after reset");
		for (int i = 0; i < 4; i++) begin
			check(ain_vec[i] == '0, "channel register not cleared by reset");
		end

		// cpu register write at the fastest rate
		@(posedge i2c_clk);
		#2;
		i_reg_byte = byte_t'($urandom);
		i_w_data   = byte_t'($urandom);
		wr_base    = u_adc_model.wr_log.size();
		ack_base   = u_adc_model.ack_cnt;
		start_set();
		wait_result();
		check(o_finish && !o_ack_err, "cpu write did not finish");
		check(u_adc_model.wr_log.size() == wr_base + 3, "cpu write byte count");
		check(u_adc_model.wr_log[wr_base] == 8'h8A, "cpu write address byte");
		check(u_adc_model.wr_log[wr_base + 1] == i_reg_byte, "cpu write register byte");
		check(u_adc_model.wr_log[wr_base + 2] == i_w_data, "cpu write data byte");
		check(u_adc_model.ack_cnt == ack_base + 3, "cpu write bytes not all acked");

		// wrong address
		@(posedge i2c_clk);
		#2 i_dev_addr = 7'h23;
		prev_ain  = ain_vec;
		wr_base   = u_adc_model.wr_log.size();
		stop_base = u_adc_model.stop_cnt;
		nack_base = u_adc_model.nack_cnt;
		start_set();
		wait_result();
		check(o_ack_err && !o_finish, "address nack not flagged");
		@(negedge i2c_clk);
		while (!o_ready) @(negedge i2c_clk);
		check(u_adc_model.nack_cnt == nack_base + 1, "wrong address not seen on the bus");
		check(u_adc_model.stop_cnt == stop_base + 1, "no stop after address nack");
		check(u_adc_model.wr_log.size() == wr_base, "bytes logged after nack");
		check(ain_vec == prev_ain, "channel register changed on nack");

		// two scan passes at the slowest rate
		@(posedge i2c_clk);
		#2;
		i_dev_addr  = 7'h45;
		i_scan_mode = 1'b1;
		i_rate_sel  = 2'd3;
		mux_base    = u_adc_model.mux_log.size();
		for (int n = 0; n < 8; n++) begin
			ch       = n % 4;
			prev_ain = ain_vec;
			start_set();
			wait_result();
			check(o_finish && !o_ack_err, "scan channel did not finish");
			check(u_adc_model.mux_log.size() == mux_base + n + 1, "mux write count");
			check(u_adc_model.mux_log[mux_base + n] == 8'h81 + 8'(ch * 16), "mux code order");
			check(!u_adc_model.rdata_early, "rdata sent while drdy high");
			for (int i = 0; i < 4; i++) begin
				if (i == ch) begin
					check(ain_vec[i] == u_adc_model.samples[i], "stored sample wrong");
				end else begin
					check(ain_vec[i] == prev_ain[i], "other channel register changed");
				end
			end
		end

		ended = 1'b1;
		$display("Verification passed");
		$finish;
	end

endmodule

//--- flist.f
ads_pkg.sv
i2c_cmd_if.sv
i2c_rate_div.sv
i2c_bus_engine.sv
adc_sequencer.sv
ads_i2c_ctrl.sv
ads_adc_model.sv
tb_ads_i2c_properties.sv
tb_ads_i2c.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f --top-module tb_ads_i2c -o tb_ads_i2c \
	&& ./obj_dir/tb_ads_i2c \
	|| exit 1
